// ==== design/cpu_pkg.sv ====
package cpu_pkg;

  localparam int data_width = 16;
  localparam int reg_count = 8;
  localparam int reg_aw = $clog2(reg_count);
  localparam int imm_width = 6;
  localparam int target_width = 12;

  typedef enum logic [3:0] {
    op_rtype = 4'd0,
    op_addi  = 4'd1,
    op_lw    = 4'd2,
    op_sw    = 4'd3,
    op_beq   = 4'd4,
    op_bne   = 4'd5,
    op_j     = 4'd6,
    op_halt  = 4'd7
  } opcode_t;

  typedef enum logic [2:0] {
    f_add = 3'd0,
    f_sub = 3'd1,
    f_and = 3'd2,
    f_or  = 3'd3,
    f_slt = 3'd4
  } funct_t;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_t;

  typedef enum logic [1:0] {
    mem_none,
    mem_load,
    mem_store
  } mem_op_t;

  // branch kind as carried from decode to execute
  localparam logic [1:0] br_none = 2'd0;
  localparam logic [1:0] br_eq   = 2'd1;
  localparam logic [1:0] br_ne   = 2'd2;
  localparam logic [1:0] br_jump = 2'd3;

  // one instruction word, three ways to read it
  typedef union packed {
    struct packed {
      opcode_t opcode;
      logic [reg_aw-1:0] rs;
      logic [reg_aw-1:0] rt;
      logic [reg_aw-1:0] rd;
      funct_t funct;
    } r_fmt;
    struct packed {
      opcode_t opcode;
      logic [reg_aw-1:0] rs;
      logic [reg_aw-1:0] rt;
      logic [imm_width-1:0] imm;
    } i_fmt;
    struct packed {
      opcode_t opcode;
      logic [target_width-1:0] target;
    } j_fmt;
  } instr_t;

endpackage

// ==== design/stage_links.sv ====
`timescale 1ns/1ps

// decode to execute
interface id_ex_link import cpu_pkg::*; #(
  parameter int addr_width = 8
);
  logic valid;
  logic [reg_aw-1:0] rs;
  logic [reg_aw-1:0] rt;
  logic [reg_aw-1:0] dest;
  logic [data_width-1:0] rs_val;
  logic [data_width-1:0] rt_val;
  logic [data_width-1:0] imm;
  alu_op_t alu_op;
  logic alu_src;
  mem_op_t mem_op;
  logic reg_write;
  logic [1:0] br_kind;
  logic [addr_width-1:0] br_target;
  logic [addr_width-1:0] jmp_target;
  logic halt;

  modport source (output valid, rs, rt, dest, rs_val, rt_val, imm, alu_op, alu_src,
                  mem_op, reg_write, br_kind, br_target, jmp_target, halt);
  modport sink (input valid, rs, rt, dest, rs_val, rt_val, imm, alu_op, alu_src,
                mem_op, reg_write, br_kind, br_target, jmp_target, halt);
endinterface

// execute to memory
interface ex_mem_link import cpu_pkg::*;;
  logic valid;
  logic reg_write;
  logic [reg_aw-1:0] dest;
  logic [data_width-1:0] alu_result;
  logic [data_width-1:0] store_data;
  mem_op_t mem_op;
  logic halt;

  modport source (output valid, reg_write, dest, alu_result, store_data, mem_op, halt);
  modport sink (input valid, reg_write, dest, alu_result, store_data, mem_op, halt);
endinterface

// writeback, seen by the register file and by forwarding
interface wb_link import cpu_pkg::*;;
  logic reg_write;
  logic [reg_aw-1:0] dest;
  logic [data_width-1:0] data;

  modport source (output reg_write, dest, data);
  modport sink (input reg_write, dest, data);
endinterface

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; #(
  parameter int addr_width = 8
) (
  input  logic clk,
  input  logic rst_n,
  input  logic stall,
  input  logic redirect,
  input  logic [addr_width-1:0] redirect_pc,
  input  logic halt_seen,
  output logic [addr_width-1:0] imem_addr,
  input  instr_t imem_data,
  output instr_t if_instr,
  output logic [addr_width-1:0] if_pc,
  output logic if_valid
);

  logic [addr_width-1:0] pc;
  // set once a HALT has passed decode, fetch never resumes
  logic stopped;

  assign imem_addr = pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
      stopped <= 1'b0;
      if_valid <= 1'b0;
    end else if (redirect) begin
      pc <= redirect_pc;
      if_valid <= 1'b0;
    end else if (stall) begin
      // load-use, hold pc and IF/ID as they are
    end else if (halt_seen || stopped) begin
      stopped <= 1'b1;
      if_valid <= 1'b0;
    end else begin
      pc <= pc + 1'b1;
      if_valid <= 1'b1;
    end
  end

  // IF/ID payload
  always_ff @(posedge clk) begin
    if (!redirect && !stall) begin
      if_instr <= imem_data;
      if_pc <= pc;
    end
  end

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; #(
  parameter int addr_width = 8
) (
  input  logic clk,
  input  logic rst_n,
  input  instr_t if_instr,
  input  logic [addr_width-1:0] if_pc,
  input  logic if_valid,
  input  logic redirect,
  wb_link.sink wb,
  id_ex_link.source id_ex,
  output logic stall,
  output logic halt_seen
);

  logic [data_width-1:0] regs [reg_count];
  opcode_t opcode;
  logic [reg_aw-1:0] rs;
  logic [reg_aw-1:0] rt;
  logic [reg_aw-1:0] dest;
  logic [data_width-1:0] imm_ext;
  logic [data_width-1:0] rs_val;
  logic [data_width-1:0] rt_val;
  alu_op_t alu_op;
  mem_op_t mem_op;
  logic [1:0] br_kind;
  logic alu_src;
  logic reg_write;
  logic halt;
  logic use_rs;
  logic use_rt;

  assign opcode = if_instr.r_fmt.opcode;
  assign rs = if_instr.r_fmt.rs;
  assign rt = if_instr.i_fmt.rt;
  assign imm_ext = {{(data_width-imm_width){if_instr.i_fmt.imm[imm_width-1]}},
                    if_instr.i_fmt.imm};

  ////////////////////////////////////////
  // control decode
  ////////////////////////////////////////

  always_comb begin
    alu_op = alu_add;
    alu_src = 1'b0;
    mem_op = mem_none;
    reg_write = 1'b0;
    dest = rt;
    br_kind = br_none;
    halt = 1'b0;
    use_rs = 1'b0;
    use_rt = 1'b0;
    case (opcode)
      op_rtype: begin
        dest = if_instr.r_fmt.rd;
        reg_write = 1'b1;
        use_rs = 1'b1;
        use_rt = 1'b1;
        case (if_instr.r_fmt.funct)
          f_sub:   alu_op = alu_sub;
          f_and:   alu_op = alu_and;
          f_or:    alu_op = alu_or;
          f_slt:   alu_op = alu_slt;
          default: alu_op = alu_add;
        endcase
      end
      op_addi: begin
        alu_src = 1'b1;
        reg_write = 1'b1;
        use_rs = 1'b1;
      end
      op_lw: begin
        alu_src = 1'b1;
        mem_op = mem_load;
        reg_write = 1'b1;
        use_rs = 1'b1;
      end
      op_sw: begin
        alu_src = 1'b1;
        mem_op = mem_store;
        use_rs = 1'b1;
        use_rt = 1'b1;
      end
      op_beq: begin
        br_kind = br_eq;
        use_rs = 1'b1;
        use_rt = 1'b1;
      end
      op_bne: begin
        br_kind = br_ne;
        use_rs = 1'b1;
        use_rt = 1'b1;
      end
      op_j:    br_kind = br_jump;
      op_halt: halt = 1'b1;
      default: ;
    endcase
    // r0 is never written, so nothing downstream has to check for it
    if (dest == '0) begin
      reg_write = 1'b0;
    end
  end

  ////////////////////////////////////////
  // register file
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.reg_write) begin
      regs[wb.dest] <= wb.data;
    end
  end

  // write-first, a writeback in this cycle is seen by the read
  assign rs_val = (wb.reg_write && wb.dest == rs) ? wb.data : regs[rs];
  assign rt_val = (wb.reg_write && wb.dest == rt) ? wb.data : regs[rt];

  // load in execute feeding the instruction here
  assign stall = if_valid && id_ex.valid && id_ex.reg_write && id_ex.mem_op == mem_load &&
                 ((use_rs && id_ex.dest == rs) || (use_rt && id_ex.dest == rt));

  assign halt_seen = if_valid && opcode == op_halt;

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex.valid <= 1'b0;
      id_ex.reg_write <= 1'b0;
      id_ex.mem_op <= mem_none;
      id_ex.br_kind <= br_none;
      id_ex.halt <= 1'b0;
    end else begin
      // stall and redirect both leave a bubble behind
      id_ex.valid <= if_valid && !stall && !redirect;
      id_ex.reg_write <= reg_write;
      id_ex.mem_op <= mem_op;
      id_ex.br_kind <= br_kind;
      id_ex.halt <= halt;
    end
  end

  always_ff @(posedge clk) begin
    id_ex.rs <= rs;
    id_ex.rt <= rt;
    id_ex.dest <= dest;
    id_ex.rs_val <= rs_val;
    id_ex.rt_val <= rt_val;
    id_ex.imm <= imm_ext;
    id_ex.alu_op <= alu_op;
    id_ex.alu_src <= alu_src;
    // branch target is pc + 1 + offset
    id_ex.br_target <= if_pc + addr_width'(1) + addr_width'(imm_ext);
    id_ex.jmp_target <= addr_width'(if_instr.j_fmt.target);
  end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; #(
  parameter int addr_width = 8
) (
  input  logic clk,
  input  logic rst_n,
  id_ex_link.sink id_ex,
  wb_link.sink wb,
  ex_mem_link.source ex_mem,
  output logic redirect,
  output logic [addr_width-1:0] redirect_pc
);

  logic [data_width-1:0] op_a;
  logic [data_width-1:0] op_b_reg;
  logic [data_width-1:0] op_b;
  logic [data_width-1:0] alu_y;
  logic mem_fwd;

  // a load result is not ready in EX/MEM, the hazard stall covers that case
  assign mem_fwd = ex_mem.reg_write && ex_mem.mem_op != mem_load;

  // newest producer wins, memory stage before writeback
  function automatic logic [data_width-1:0] fwd_pick(
    input logic [reg_aw-1:0] idx,
    input logic [data_width-1:0] reg_val
  );
    if (mem_fwd && ex_mem.dest == idx) begin
      return ex_mem.alu_result;
    end else if (wb.reg_write && wb.dest == idx) begin
      return wb.data;
    end
    return reg_val;
  endfunction

  always_comb begin
    op_a = fwd_pick(id_ex.rs, id_ex.rs_val);
    op_b_reg = fwd_pick(id_ex.rt, id_ex.rt_val);
  end

  assign op_b = id_ex.alu_src ? id_ex.imm : op_b_reg;

  ////////////////////////////////////////
  // alu
  ////////////////////////////////////////

  always_comb begin
    case (id_ex.alu_op)
      alu_add: alu_y = op_a + op_b;
      alu_sub: alu_y = op_a - op_b;
      alu_and: alu_y = op_a & op_b;
      alu_or:  alu_y = op_a | op_b;
      alu_slt: alu_y = {{(data_width-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: alu_y = '0;
    endcase
  end

  // branch outcome, compares the forwarded register values
  always_comb begin
    redirect = 1'b0;
    if (id_ex.valid) begin
      case (id_ex.br_kind)
        br_eq:   redirect = op_a == op_b_reg;
        br_ne:   redirect = op_a != op_b_reg;
        br_jump: redirect = 1'b1;
        default: redirect = 1'b0;
      endcase
    end
  end

  assign redirect_pc = (id_ex.br_kind == br_jump) ? id_ex.jmp_target : id_ex.br_target;

  ////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_mem.valid <= 1'b0;
      ex_mem.reg_write <= 1'b0;
      ex_mem.mem_op <= mem_none;
      ex_mem.halt <= 1'b0;
    end else begin
      ex_mem.valid <= id_ex.valid;
      ex_mem.reg_write <= id_ex.valid && id_ex.reg_write;
      ex_mem.mem_op <= id_ex.valid ? id_ex.mem_op : mem_none;
      ex_mem.halt <= id_ex.valid && id_ex.halt;
    end
  end

  always_ff @(posedge clk) begin
    ex_mem.dest <= id_ex.dest;
    ex_mem.alu_result <= alu_y;
    ex_mem.store_data <= op_b_reg;
  end

endmodule

// ==== design/memory_stage.sv ====
`timescale 1ns/1ps

module memory_stage import cpu_pkg::*; #(
  parameter int dmem_words = 64
) (
  input  logic clk,
  input  logic rst_n,
  ex_mem_link.sink ex_mem,
  wb_link.source wb,
  output logic st_valid,
  output logic [$clog2(dmem_words)-1:0] st_addr,
  output logic [data_width-1:0] st_data,
  output logic halted
);

  localparam int dmem_aw = $clog2(dmem_words);

  logic [data_width-1:0] dmem [dmem_words];
  logic [dmem_aw-1:0] dmem_idx;
  // MEM/WB payload
  logic wb_is_load;
  logic [data_width-1:0] wb_alu;
  logic [data_width-1:0] wb_load;

  // word address wraps at the memory depth
  assign dmem_idx = dmem_aw'(ex_mem.alu_result % dmem_words);

  assign st_valid = ex_mem.valid && ex_mem.mem_op == mem_store;
  assign st_addr = dmem_idx;
  assign st_data = ex_mem.store_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < dmem_words; i++) begin
        dmem[i] <= '0;
      end
    end else if (st_valid) begin
      dmem[dmem_idx] <= ex_mem.store_data;
    end
  end

  ////////////////////////////////////////
  // MEM/WB register and halt
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb.reg_write <= 1'b0;
      halted <= 1'b0;
    end else begin
      wb.reg_write <= ex_mem.reg_write;
      // sticky until the next reset
      halted <= halted || (ex_mem.valid && ex_mem.halt);
    end
  end

  always_ff @(posedge clk) begin
    wb.dest <= ex_mem.dest;
    wb_is_load <= ex_mem.mem_op == mem_load;
    wb_alu <= ex_mem.alu_result;
    wb_load <= dmem[dmem_idx];
  end

  assign wb.data = wb_is_load ? wb_load : wb_alu;

endmodule

// ==== design/processor.sv ====
`timescale 1ns/1ps

module processor import cpu_pkg::*; #(
  parameter int addr_width = 8,
  parameter int dmem_words = 64
) (
  input  logic clk,
  input  logic rst_n,
  output logic [addr_width-1:0] imem_addr,
  input  instr_t imem_data,
  output logic wb_valid,
  output logic [reg_aw-1:0] wb_reg,
  output logic [data_width-1:0] wb_data,
  output logic st_valid,
  output logic [$clog2(dmem_words)-1:0] st_addr,
  output logic [data_width-1:0] st_data,
  output logic halted
);

  logic stall;
  logic redirect;
  logic halt_seen;
  logic if_valid;
  logic [addr_width-1:0] redirect_pc;
  logic [addr_width-1:0] if_pc;
  instr_t if_instr;

  id_ex_link #(.addr_width(addr_width)) id_ex ();
  ex_mem_link ex_mem ();
  wb_link wb ();

  fetch_stage #(.addr_width(addr_width)) u_fetch (
    .clk(clk),
    .rst_n(rst_n),
    .stall(stall),
    .redirect(redirect),
    .redirect_pc(redirect_pc),
    .halt_seen(halt_seen),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .if_instr(if_instr),
    .if_pc(if_pc),
    .if_valid(if_valid)
  );

  decode_stage #(.addr_width(addr_width)) u_decode (
    .clk(clk),
    .rst_n(rst_n),
    .if_instr(if_instr),
    .if_pc(if_pc),
    .if_valid(if_valid),
    .redirect(redirect),
    .wb(wb.sink),
    .id_ex(id_ex.source),
    .stall(stall),
    .halt_seen(halt_seen)
  );

  execute_stage #(.addr_width(addr_width)) u_execute (
    .clk(clk),
    .rst_n(rst_n),
    .id_ex(id_ex.sink),
    .wb(wb.sink),
    .ex_mem(ex_mem.source),
    .redirect(redirect),
    .redirect_pc(redirect_pc)
  );

  memory_stage #(.dmem_words(dmem_words)) u_memory (
    .clk(clk),
    .rst_n(rst_n),
    .ex_mem(ex_mem.sink),
    .wb(wb.source),
    .st_valid(st_valid),
    .st_addr(st_addr),
    .st_data(st_data),
    .halted(halted)
  );

  // writeback observation
  assign wb_valid = wb.reg_write;
  assign wb_reg = wb.dest;
  assign wb_data = wb.data;

endmodule

// ==== bench/tb_program_pkg.sv ====
package tb_program_pkg;
  import cpu_pkg::*;

  localparam int tb_addr_width = 8;
  localparam int tb_dmem_words = 64;
  localparam int tb_dmem_aw = $clog2(tb_dmem_words);
  localparam int body_len = 40;
  // random body plus the closing HALT
  localparam int prog_words = body_len + 1;

  typedef struct packed {
    logic [reg_aw-1:0] dest;
    logic [data_width-1:0] data;
  } reg_write_t;

  typedef struct packed {
    logic [tb_dmem_aw-1:0] addr;
    logic [data_width-1:0] data;
  } store_t;

  instr_t prog [prog_words];
  reg_write_t exp_writes [$];
  store_t exp_stores [$];

  function automatic int pick(inout integer seed, input int n);
    return {$random(seed)} % n;
  endfunction

  // forward-only branches and jumps, so every program reaches its HALT
  task automatic generate_program(inout integer seed);
    int kind;
    int max_off;
    logic [reg_aw-1:0] last_dest;
    instr_t w;
    last_dest = '0;
    for (int i = 0; i < body_len; i++) begin
      w = '0;
      kind = pick(seed, 16);
      // half the time read the previous result, for back-to-back dependencies
      if (pick(seed, 2) == 0) begin
        w.i_fmt.rs = last_dest;
      end else begin
        w.i_fmt.rs = reg_aw'(pick(seed, reg_count));
      end
      w.i_fmt.rt = reg_aw'(pick(seed, reg_count));
      w.i_fmt.imm = imm_width'(pick(seed, 64));
      if (kind < 6) begin
        w.r_fmt.opcode = op_rtype;
        w.r_fmt.rd = reg_aw'(pick(seed, reg_count));
        w.r_fmt.funct = funct_t'(3'(pick(seed, 5)));
        last_dest = w.r_fmt.rd;
      end else if (kind < 9) begin
        w.i_fmt.opcode = op_addi;
        last_dest = w.i_fmt.rt;
      end else if (kind < 13) begin
        // mostly off r0, so stores and later loads meet at the same words
        if (pick(seed, 2) == 0) begin
          w.i_fmt.rs = '0;
          w.i_fmt.imm = imm_width'(pick(seed, 32));
        end
        if (kind < 11) begin
          w.i_fmt.opcode = op_lw;
          last_dest = w.i_fmt.rt;
        end else begin
          w.i_fmt.opcode = op_sw;
        end
      end else if (kind < 15) begin
        max_off = (body_len - 1 - i < 31) ? body_len - 1 - i : 31;
        w.i_fmt.opcode = (kind == 13) ? op_beq : op_bne;
        if (pick(seed, 4) == 0) begin
          w.i_fmt.rt = w.i_fmt.rs;
        end
        w.i_fmt.imm = imm_width'(pick(seed, max_off + 1));
      end else begin
        w.j_fmt.opcode = op_j;
        w.j_fmt.target = target_width'(i + 1 + pick(seed, body_len - i));
      end
      prog[i] = w;
    end
    w = '0;
    w.j_fmt.opcode = op_halt;
    prog[body_len] = w;
  endtask

  // instruction-level reference model that fills the two expectation queues
  task automatic run_model();
    logic [data_width-1:0] regs [reg_count];
    logic [data_width-1:0] mem [tb_dmem_words];
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
    logic [data_width-1:0] imm;
    logic [data_width-1:0] sum;
    logic [data_width-1:0] val;
    logic [reg_aw-1:0] dest;
    logic [tb_addr_width-1:0] pc;
    logic wr;
    logic running;
    instr_t w;
    reg_write_t wrec;
    store_t srec;
    exp_writes.delete();
    exp_stores.delete();
    foreach (regs[i]) begin
      regs[i] = '0;
    end
    foreach (mem[i]) begin
      mem[i] = '0;
    end
    pc = '0;
    running = 1'b1;
    while (running) begin
      w = prog[pc];
      a = regs[w.i_fmt.rs];
      b = regs[w.i_fmt.rt];
      imm = data_width'($signed(w.i_fmt.imm));
      sum = a + imm;
      wr = 1'b0;
      dest = w.i_fmt.rt;
      val = '0;
      pc = pc + 1'b1;
      case (w.r_fmt.opcode)
        op_rtype: begin
          wr = 1'b1;
          dest = w.r_fmt.rd;
          case (w.r_fmt.funct)
            f_sub:   val = a - b;
            f_and:   val = a & b;
            f_or:    val = a | b;
            f_slt:   val = ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            default: val = a + b;
          endcase
        end
        op_addi: begin
          wr = 1'b1;
          val = sum;
        end
        op_lw: begin
          wr = 1'b1;
          val = mem[sum % tb_dmem_words];
        end
        op_sw: begin
          mem[sum % tb_dmem_words] = b;
          srec.addr = tb_dmem_aw'(sum % tb_dmem_words);
          srec.data = b;
          exp_stores.push_back(srec);
        end
        op_beq: begin
          if (a == b) begin
            pc = pc + tb_addr_width'(imm);
          end
        end
        op_bne: begin
          if (a != b) begin
            pc = pc + tb_addr_width'(imm);
          end
        end
        op_j:    pc = tb_addr_width'(w.j_fmt.target);
        op_halt: running = 1'b0;
        default: ;
      endcase
      // r0 stays zero and is never reported
      if (wr && dest != '0) begin
        regs[dest] = val;
        wrec.dest = dest;
        wrec.data = val;
        exp_writes.push_back(wrec);
      end
    end
  endtask

endpackage

// ==== bench/tb_processor.sv ====
`timescale 1ns/1ps

module tb_processor
  import cpu_pkg::*;
  import tb_program_pkg::*;
();

  localparam int clk_period = 20;
  localparam int reset_cycles = 10;
  localparam int num_tests = 20;
  localparam int st_aw = $clog2(tb_dmem_words);
  // four cycles per instruction is a loose bound on a run
  localparam int test_ns = prog_words * 4 * clk_period;
  localparam int watchdog_ns = num_tests * (test_ns + reset_cycles * clk_period);

  logic clk = 1'b0;
  logic rst_n;
  logic [tb_addr_width-1:0] imem_addr;
  instr_t imem_data;
  logic wb_valid;
  logic [reg_aw-1:0] wb_reg;
  logic [data_width-1:0] wb_data;
  logic st_valid;
  logic [st_aw-1:0] st_addr;
  logic [data_width-1:0] st_data;
  logic halted;

  integer seed;
  int errors;
  int failed_tests;
  int writes_seen;
  int stores_seen;

  processor #(
    .addr_width(tb_addr_width),
    .dmem_words(tb_dmem_words)
  ) uut (
    .clk(clk),
    .rst_n(rst_n),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .wb_valid(wb_valid),
    .wb_reg(wb_reg),
    .wb_data(wb_data),
    .st_valid(st_valid),
    .st_addr(st_addr),
    .st_data(st_data),
    .halted(halted)
  );

  always #(clk_period / 2) clk = ~clk;

  ////////////////////////////////////////
  // instruction memory
  ////////////////////////////////////////

  function automatic instr_t fetch_word(input logic [tb_addr_width-1:0] addr);
    instr_t w;
    if (int'(addr) < prog_words) begin
      w = prog[addr];
    end else begin
      // past the end, a HALT carrying its own address
      w.j_fmt.opcode = op_halt;
      w.j_fmt.target = target_width'(addr);
    end
    return w;
  endfunction

  initial begin
    imem_data = '0;
    forever begin
      @(posedge clk);
      #1;
      imem_data = fetch_word(imem_addr);
    end
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic check_writeback();
    reg_write_t exp;
    if (wb_valid) begin
      writes_seen++;
      assert (wb_reg != '0) else begin
        $display("register zero was written at %0t", $time);
        errors++;
      end
      assert (exp_writes.size() > 0) else begin
        $display("unexpected write to r%0d at %0t, no write was expected", wb_reg, $time);
        errors++;
      end
      if (exp_writes.size() > 0) begin
        exp = exp_writes.pop_front();
        assert (wb_reg == exp.dest && wb_data == exp.data) else begin
          $display("Mismatch at %0t: write r%0d = %h, expected r%0d = %h",
                   $time, wb_reg, wb_data, exp.dest, exp.data);
          errors++;
        end
      end
    end
  endtask

  task automatic check_store();
    store_t exp;
    if (st_valid) begin
      stores_seen++;
      assert (exp_stores.size() > 0) else begin
        $display("unexpected store to word %0d at %0t, no store was expected", st_addr, $time);
        errors++;
      end
      if (exp_stores.size() > 0) begin
        exp = exp_stores.pop_front();
        assert (st_addr == exp.addr && st_data == exp.data) else begin
          $display("Mismatch at %0t: store [%0d] = %h, expected [%0d] = %h",
                   $time, st_addr, st_data, exp.addr, exp.data);
          errors++;
        end
      end
    end
  endtask

  task automatic check_drained();
    assert (exp_writes.size() == 0 && exp_stores.size() == 0) else begin
      $display("halted at %0t with %0d writes and %0d stores still outstanding",
               $time, exp_writes.size(), exp_stores.size());
      errors++;
    end
  endtask

  // one program from reset to halted
  task automatic run_test(input int test_id);
    int start_errors;
    logic done;
    start_errors = errors;
    writes_seen = 0;
    stores_seen = 0;
    generate_program(seed);
    run_model();
    @(posedge clk);
    #1;
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    done = 1'b0;
    while (!done) begin
      // outputs are settled by the falling edge
      @(negedge clk);
      check_writeback();
      check_store();
      if (halted) begin
        check_drained();
        done = 1'b1;
      end
    end
    if (errors == start_errors) begin
      $display("test %0d: %0d writes, %0d stores, ok", test_id, writes_seen, stores_seen);
    end else begin
      failed_tests++;
      $display("test %0d: %0d writes, %0d stores, %0d errors", test_id, writes_seen,
               stores_seen, errors - start_errors);
    end
  endtask

  initial begin
    rst_n = 1'b0;
    seed = 61;
    errors = 0;
    failed_tests = 0;
    for (int t = 0; t < num_tests; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d failed, %0d errors", num_tests, failed_tests, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== processor.f ====
design/cpu_pkg.sv
design/stage_links.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/processor.sv
bench/tb_program_pkg.sv
bench/tb_processor.sv

// ==== Makefile ====
TOP := tb_processor

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) \
		-f processor.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qxF '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
